// File: fir_types_pkg.sv
`default_nettype none

package fir_types_pkg;

    // ======================================================================
    // datapath widths
    // ======================================================================
    localparam int SAMPLE_W = 16;
    localparam int COEFF_W  = 16;
    localparam int PREADD_W = SAMPLE_W + 1;    // sample plus its mirror
    localparam int ACC_W    = 32;

    // ======================================================================
    // datapath types
    // ======================================================================

    // one real input sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // one unique filter coefficient
    typedef logic signed [COEFF_W-1:0]  coeff_t;

    typedef logic signed [PREADD_W-1:0] preadd_t;   // folded sample pair

    // product, cascaded partial sum and filter output
    typedef logic signed [ACC_W-1:0]    acc_t;

endpackage

`default_nettype wire

// File: fir_cfg_pkg.sv
`default_nettype none

package fir_cfg_pkg;
    import fir_types_pkg::*;

    // number of unique coefficients, folds into 2*n-1 taps
    localparam int DEFAULT_TAP_COUNT = 5;

    // low-pass half, outer tap first, centre tap last
    localparam coeff_t DEFAULT_COEFFS [DEFAULT_TAP_COUNT] = '{
        -16'sd42, 16'sd0, 16'sd427, 16'sd1146, 16'sd1600
    };

    localparam int TAP_PIPE_EXTRA = 4;  // in delay, pre-add, multiply, cascade
    localparam int FLUSH_EXTRA    = 1;

    // active cycles from newest input to its output
    function automatic int fir_latency(input int tap_count);
        return tap_count + TAP_PIPE_EXTRA;
    endfunction

    // cycles of zero fill after the last sample of a packet
    function automatic int fir_flush_len(input int tap_count);
        return 3 * tap_count + FLUSH_EXTRA;
    endfunction

endpackage

`default_nettype wire

// File: fir_feed_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fir_feed_if
    import fir_types_pkg::*;
();

    logic    step;          // active cycle, every datapath register advances
    logic    flushing;      // zero fill after the last sample
    sample_t feed_sample;   // new sample, zero when not offered
    sample_t fold_sample;   // mirror operand shared by the outer taps

    // control owns the cycle qualifiers
    modport ctrl (
        output step,
        output flushing
    );

    // delay line feeds both operands into the row of taps
    modport line (
        input  step,
        input  flushing,
        output feed_sample,
        output fold_sample
    );

    modport chain (
        input  step,
        input  feed_sample,
        input  fold_sample
    );

endinterface

`default_nettype wire

// File: fir_sym_tap.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sym_tap
    import fir_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    step,
    input  coeff_t  coeff,
    input  sample_t sample_in,
    input  sample_t mirror_in,
    input  acc_t    casc_in,
    output sample_t sample_out,
    output acc_t    casc_out
);

    sample_t din_d1;
    sample_t din_d2;
    sample_t mirror_q;
    preadd_t preadd_q;
    acc_t    mult_q;
    acc_t    casc_q;

    // ======================================================================
    // delay, pre-add, multiply, cascade add
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            din_d1   <= '0;
            din_d2   <= '0;
            mirror_q <= '0;
            preadd_q <= '0;
            mult_q   <= '0;
            casc_q   <= '0;
        end else if (step) begin
            // two stages per tap, partial sums move one,
            // so samples meet the sum of the next tap in time
            din_d1   <= sample_in;
            din_d2   <= din_d1;
            mirror_q <= mirror_in;

            // fold the symmetric pair before the multiply
            preadd_q <= preadd_t'(din_d2) + preadd_t'(mirror_q);
            mult_q   <= acc_t'(preadd_q) * acc_t'(coeff);
            casc_q   <= mult_q + casc_in;
        end
    end

    assign sample_out = din_d2;
    assign casc_out   = casc_q;     // partial sum up to this tap

endmodule

`default_nettype wire

// File: fir_tap_chain.sv
`timescale 1ns/1ps
`default_nettype none

module fir_tap_chain
    import fir_types_pkg::*, fir_cfg_pkg::*;
#(
    parameter int     TAP_COUNT            = DEFAULT_TAP_COUNT,
    parameter coeff_t COEFFS [TAP_COUNT]   = DEFAULT_COEFFS
) (
    input  logic      clk,
    input  logic      rst,
    fir_feed_if.chain feed,
    output acc_t      sum
);

    sample_t delay_link [TAP_COUNT];    // sample passed on, two registers per tap
    acc_t    casc_link  [TAP_COUNT];    // running partial sum

    // ======================================================================
    // systolic row, outer tap first
    // ======================================================================
    for (genvar k = 0; k < TAP_COUNT; k++) begin : g_tap
        sample_t tap_sample;
        sample_t tap_mirror;
        acc_t    tap_casc;

        if (k == 0) begin : g_first
            assign tap_sample = feed.feed_sample;
            assign tap_casc   = '0;
        end else begin : g_next
            assign tap_sample = delay_link[k-1];
            assign tap_casc   = casc_link[k-1];
        end

        // centre coefficient counted once
        if (k == TAP_COUNT - 1) begin : g_centre
            assign tap_mirror = '0;
        end else begin : g_outer
            assign tap_mirror = feed.fold_sample;
        end

        fir_sym_tap u_tap (
            .clk        (clk),
            .rst        (rst),
            .step       (feed.step),
            .coeff      (COEFFS[k]),
            .sample_in  (tap_sample),
            .mirror_in  (tap_mirror),
            .casc_in    (tap_casc),
            .sample_out (delay_link[k]),
            .casc_out   (casc_link[k])
        );
    end

    assign sum = casc_link[TAP_COUNT-1];

endmodule

`default_nettype wire

// File: fir_fold_line.sv
`timescale 1ns/1ps
`default_nettype none

module fir_fold_line
    import fir_types_pkg::*, fir_cfg_pkg::*;
#(
    parameter int TAP_COUNT = DEFAULT_TAP_COUNT
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  sample_t  in_sample,
    fir_feed_if.line feed
);

    // entry i holds the sample i+1 active positions back,
    // the last entry lines up with the centre of odd symmetry
    localparam int LINE_LEN = 2 * TAP_COUNT - 1;

    sample_t line_q [LINE_LEN];
    sample_t head;

    // samples offered during a flush do not enter the packet
    assign head = (in_valid && !feed.flushing) ? in_sample : '0;

    assign feed.feed_sample = head;

    // ======================================================================
    // sample delay line
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINE_LEN; i++) begin
                line_q[i] <= '0;
            end
        end else if (feed.step) begin
            line_q[0] <= head;      // zero while flushing
            for (int i = 1; i < LINE_LEN; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // mirror of the sample entering the row, each tap registers it once more
    assign feed.fold_sample = line_q[LINE_LEN-1];

endmodule

`default_nettype wire

// File: fir_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fir_flush_ctrl
    import fir_cfg_pkg::*;
#(
    parameter int TAP_COUNT = DEFAULT_TAP_COUNT
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     in_last,
    fir_feed_if.ctrl feed,
    output logic     out_valid,
    output logic     out_last
);

    localparam int LATENCY   = fir_latency(TAP_COUNT);
    localparam int FLUSH_LEN = fir_flush_len(TAP_COUNT);
    localparam int CNT_W     = $clog2(FLUSH_LEN + 1);

    typedef enum logic {
        ST_STREAM,
        ST_FLUSH
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   flush_cnt;
    logic [LATENCY-1:0] valid_pipe;     // one bit per active position
    logic               flushing;
    logic               flushing_q;

    assign flushing      = (state == ST_FLUSH);
    assign feed.flushing = flushing;
    assign feed.step     = in_valid | flushing;   // sample offered or draining

    // ======================================================================
    // streaming / flushing state machine
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_STREAM;
            flush_cnt <= '0;
        end else begin
            case (state)
                ST_STREAM: begin
                    flush_cnt <= '0;
                    if (in_valid && in_last) begin   // last only counts with valid
                        state <= ST_FLUSH;
                    end
                end
                ST_FLUSH: begin
                    if (flush_cnt == CNT_W'(FLUSH_LEN - 1)) begin
                        state     <= ST_STREAM;
                        flush_cnt <= '0;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ======================================================================
    // output valid and packet end
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else if (feed.step) begin
            valid_pipe <= {valid_pipe[LATENCY-2:0], 1'b1};  // one more position seen
        end
    end

    // head is cleared in stalled cycles
    assign out_valid = valid_pipe[LATENCY-1] & feed.step;

    always_ff @(posedge clk) begin
        if (rst) begin
            flushing_q <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            flushing_q <= flushing;
            out_last   <= flushing_q & ~flushing;   // falling edge of flush
        end
    end

endmodule

`default_nettype wire

// File: fir_sym_filter.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sym_filter
    import fir_types_pkg::*, fir_cfg_pkg::*;
#(
    parameter int     TAP_COUNT          = DEFAULT_TAP_COUNT,
    parameter coeff_t COEFFS [TAP_COUNT] = DEFAULT_COEFFS
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  logic    in_last,
    input  sample_t in_sample,
    output logic    out_valid,
    output logic    out_last,
    output acc_t    out_sample
);

    fir_feed_if feed ();

    // ======================================================================
    // control, delay line, systolic row
    // ======================================================================
    fir_flush_ctrl #(
        .TAP_COUNT (TAP_COUNT)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .feed      (feed),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    fir_fold_line #(
        .TAP_COUNT (TAP_COUNT)
    ) u_fold_line (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .feed      (feed)
    );

    fir_tap_chain #(
        .TAP_COUNT (TAP_COUNT),
        .COEFFS    (COEFFS)
    ) u_tap_chain (
        .clk  (clk),
        .rst  (rst),
        .feed (feed),
        .sum  (out_sample)      // last cascade is the output sample
    );

endmodule

`default_nettype wire

// File: fir_sym_filter_props.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sym_filter_props
    import fir_cfg_pkg::*;
#(
    parameter int TAP_COUNT = DEFAULT_TAP_COUNT
) (
    input logic clk,
    input logic rst,
    input logic step,
    input logic flushing,
    input logic out_valid,
    input logic out_last
);

    localparam int FLUSH_LEN = 3 * TAP_COUNT + FLUSH_EXTRA;

    int   fail_count = 0;   // assertion failures so far
    logic filled;           // pipeline has produced an output

    always_ff @(posedge clk) begin
        if (rst) begin
            filled <= 1'b0;
        end else if (out_valid) begin
            filled <= 1'b1;
        end
    end

    a_last_pulse: assert property (@(posedge clk) disable iff (rst) out_last |=> !out_last)
        else begin
            fail_count++;
            $error("out_last held for more than one cycle");
        end

    // out_valid only in active cycles, and in every one once the pipeline is full
    a_valid_step: assert property (@(posedge clk) disable iff (rst)
        (filled || out_valid) |-> (out_valid == step))
        else begin
            fail_count++;
            $error("out_valid does not follow step once the pipeline is full");
        end

    // zero fill lasts the whole flush length
    a_flush_len: assert property (@(posedge clk) disable iff (rst)
        $rose(flushing) |-> ##FLUSH_LEN $fell(flushing))
        else begin
            fail_count++;
            $error("flushing did not fall %0d cycles after it rose", FLUSH_LEN);
        end

endmodule

bind fir_sym_filter fir_sym_filter_props #(.TAP_COUNT (TAP_COUNT)) u_props (
    .clk       (clk),
    .rst       (rst),
    .step      (feed.step),
    .flushing  (feed.flushing),
    .out_valid (out_valid),
    .out_last  (out_last)
);

`default_nettype wire

// File: tb_fir_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;     // released between sampling edges
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tb_fir_sym_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir_sym_filter
    import fir_types_pkg::*, fir_cfg_pkg::*;
();

    localparam int     TAP_COUNT   = DEFAULT_TAP_COUNT;
    localparam int     NUM_TAPS    = 2 * TAP_COUNT - 1;
    localparam int     LATENCY     = TAP_COUNT + TAP_PIPE_EXTRA;
    localparam int     FLUSH_LEN   = 3 * TAP_COUNT + FLUSH_EXTRA;
    localparam int     LAST_DELAY  = 3 * TAP_COUNT + 2;   // edges from in_last to out_last
    localparam int     PERIOD_NS   = 40;
    localparam int     RAND_PKTS   = 6;
    localparam int     B2B_PKTS    = 3;
    localparam int     MAX_GAP     = 3;
    localparam int     PKT_CYCLES  = 19 * (MAX_GAP + 1) + LAST_DELAY + 4 + MAX_GAP;
    localparam int     RUN_CYCLES  = 8 + 20 + (RAND_PKTS + B2B_PKTS + 2) * PKT_CYCLES;
    localparam longint WATCHDOG_NS = 2 * longint'(RUN_CYCLES) * PERIOD_NS;
    localparam sample_t IMPULSE    = 16'sd7919;

    logic    clk;
    logic    rst;
    logic    in_valid;
    logic    in_last;
    sample_t in_sample;
    logic    out_valid;
    logic    out_last;
    acc_t    out_sample;

    logic [31:0] lfsr = 32'h159e_c356;
    coeff_t      h [NUM_TAPS];          // folded coefficients
    sample_t     hist [$];              // one entry per active cycle
    sample_t     pkt_q [$];
    acc_t        captured [$];
    int          since_last = 0;        // model cycles since in_last was taken
    int          cycle_no = 0;
    int          accept_cycle = 0;
    int          pulse_cycle = 0;
    int          pulses = 0;
    int          pulses_at_start = 0;
    int          errors_at_start = 0;
    logic        last_seen = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    tb_fir_clk_gen #(.PERIOD_NS (PERIOD_NS), .RESET_CYCLES (8)) u_clk_gen (.clk (clk), .rst (rst));

    fir_sym_filter #(
        .TAP_COUNT (TAP_COUNT),
        .COEFFS    (DEFAULT_COEFFS)
    ) fir_sym_filter_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_sample (out_sample)
    );

    // ======================================================================
    // stimulus source, model and compare
    // ======================================================================
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);   // galois step
        end
        return bits;
    endfunction

    // convolution over the active-cycle history
    function automatic acc_t model_out(input int pos);
        longint acc;
        int     idx;
        acc = 0;
        for (int m = 0; m < NUM_TAPS; m++) begin
            idx = pos - LATENCY - m;
            if (idx >= 0) begin
                acc += longint'(h[m]) * longint'(hist[idx]);
            end
        end
        return acc_t'(acc);
    endfunction

    task automatic check_sample(input string name, input acc_t got, input acc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // drive on the falling edge and check before the next rising edge
    task automatic run_cycle(input logic valid, input logic last, input sample_t sample);
        logic flushing_exp;
        logic exp_valid;
        logic exp_last;
        acc_t exp_out;
        @(negedge clk);
        in_valid     = valid;
        in_last      = last;
        in_sample    = sample;
        flushing_exp = (since_last >= 1) && (since_last <= FLUSH_LEN);
        exp_last     = (since_last == LAST_DELAY + 1);
        exp_valid    = 1'b0;
        exp_out      = '0;
        if (valid || flushing_exp) begin
            hist.push_back((valid && !flushing_exp) ? sample : sample_t'(0));
            exp_valid = (hist.size() > LATENCY);
            exp_out   = model_out(hist.size() - 1);
        end
        #(PERIOD_NS / 4);   // outputs settled, rising edge still ahead
        check_flag("out_valid", out_valid, exp_valid);
        check_flag("out_last", out_last, exp_last);
        if (exp_valid) begin
            check_sample("out_sample", out_sample, exp_out);
        end
        if (out_valid) begin
            captured.push_back(out_sample);
        end
        last_seen = out_last;
        if (out_last) begin
            pulses++;
            pulse_cycle = cycle_no;
        end
        if (since_last == LAST_DELAY + 1) begin
            since_last = 0;
        end else if (since_last != 0) begin
            since_last++;
        end
        if (valid && last && !flushing_exp) begin
            since_last   = 1;
            accept_cycle = cycle_no;
        end
        cycle_no++;
    endtask

    task automatic idle_cycle();
        // in_last alone is ignored
        run_cycle(1'b0, take_bits(1) != 32'd0, sample_t'(take_bits(16)));
    endtask

    task automatic fill_random(input int len);
        pkt_q.delete();
        repeat (len) pkt_q.push_back(sample_t'(take_bits(16)));
    endtask

    // samples with optional gaps, then idle until out_last
    task automatic send_packet(input logic gaps);
        int gap;
        int waited;
        for (int i = 0; i < pkt_q.size(); i++) begin
            gap = 0;
            while (gaps && gap < MAX_GAP && take_bits(2) == 32'd0) begin
                idle_cycle();
                gap++;
            end
            run_cycle(1'b1, i == pkt_q.size() - 1, pkt_q[i]);
        end
        waited    = 0;
        last_seen = 1'b0;
        while (!last_seen && waited < LAST_DELAY + 4) begin
            idle_cycle();
            waited++;
        end
        if (!last_seen) begin
            note_failure($sformatf("out_last did not arrive within %0d cycles", waited));
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        pulses_at_start = pulses;
        captured.delete();
    endtask

    task automatic end_test(input string name, input int packets);
        if (pulses - pulses_at_start != packets) begin
            note_failure($sformatf("%s: out_last pulsed %0d times for %0d packets",
                                   name, pulses - pulses_at_start, packets));
        end
        tests++;
        $display("test %-12s %s (%0d errors)", name,
                 (errors == errors_at_start) ? "ok" : "FAIL", errors - errors_at_start);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_sample = '0;
        for (int m = 0; m < TAP_COUNT; m++) begin
            h[m]                = DEFAULT_COEFFS[m];
            h[NUM_TAPS - 1 - m] = DEFAULT_COEFFS[m];    // mirror, centre once
        end
        wait (rst === 1'b0);

        begin_test();
        repeat (20) idle_cycle();
        end_test("reset_idle", 0);

        begin_test();
        pkt_q.delete();
        pkt_q.push_back(IMPULSE);
        pkt_q.push_back(sample_t'(0));
        send_packet(1'b0);
        if (captured.size() != NUM_TAPS) begin
            note_failure($sformatf("impulse gave %0d outputs", captured.size()));
        end
        for (int m = 0; m < NUM_TAPS && m < captured.size(); m++) begin
            check_sample("impulse out_sample", captured[m], acc_t'(h[m]) * acc_t'(IMPULSE));
        end
        end_test("impulse", 1);

        begin_test();
        repeat (RAND_PKTS) begin
            fill_random(4 + int'(take_bits(4)));
            send_packet(1'b1);
            repeat (int'(take_bits(2))) idle_cycle();
        end
        end_test("random", RAND_PKTS);

        begin_test();
        pkt_q.delete();
        repeat (8) pkt_q.push_back(take_bits(1) ? sample_t'(16'sh8000) : sample_t'(16'sh7fff));
        send_packet(1'b1);
        if (pulse_cycle - accept_cycle - 1 != LAST_DELAY) begin
            note_failure($sformatf("out_last came %0d edges after in_last, not %0d",
                                   pulse_cycle - accept_cycle - 1, LAST_DELAY));
        end
        end_test("flush", 1);

        begin_test();
        repeat (B2B_PKTS) begin
            fill_random(4 + int'(take_bits(3)));
            send_packet(1'b0);      // next packet right after out_last
        end
        end_test("back_to_back", B2B_PKTS);

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, fir_sym_filter_inst.u_props.fail_count);
        if (errors == 0 && fir_sym_filter_inst.u_props.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: fir_sym_filter.f
fir_types_pkg.sv
fir_cfg_pkg.sv
fir_feed_if.sv
fir_sym_tap.sv
fir_tap_chain.sv
fir_fold_line.sv
fir_flush_ctrl.sv
fir_sym_filter.sv
fir_sym_filter_props.sv
tb_fir_clk_gen.sv
tb_fir_sym_filter.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_fir_sym_filter
FILELIST  := fir_sym_filter.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
